// ==== hdl/mipsLiteDefs.svh ====
`ifndef MIPS_LITE_DEFS_SVH
`define MIPS_LITE_DEFS_SVH

`define WORD_W     32
`define REG_IDX_W  5
`define RESET_PC   32'h0000_0000
`define LINK_REG   5'd31       // JAL destination

// Primary opcodes
`define OP_RTYPE   6'h00
`define OP_J       6'h02
`define OP_JAL     6'h03
`define OP_BEQ     6'h04
`define OP_BNE     6'h05
`define OP_ADDIU   6'h09
`define OP_ORI     6'h0D
`define OP_LUI     6'h0F
`define OP_LW      6'h23
`define OP_SW      6'h2B

// Funct field, R format only
`define FN_SLL     6'h00
`define FN_ADDU    6'h21
`define FN_SUBU    6'h23
`define FN_AND     6'h24
`define FN_OR      6'h25
`define FN_XOR     6'h26
`define FN_SLT     6'h2A

`endif

// ==== hdl/mipsLitePkg.sv ====
`include "mipsLiteDefs.svh"

package mipsLitePkg;

    typedef logic [`WORD_W-1:0]    word_t;
    typedef logic [`REG_IDX_W-1:0] regIdx_t;

    // Three views of the same instruction word
    typedef struct packed {
        logic [5:0] op;
        regIdx_t    rs;
        regIdx_t    rt;
        regIdx_t    rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFmt_t;

    typedef struct packed {
        logic [5:0]  op;
        regIdx_t     rs;
        regIdx_t     rt;
        logic [15:0] imm;
    } iFmt_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] target;   // Word index within the 256 MB region
    } jFmt_t;

    typedef union packed {
        rFmt_t r;
        iFmt_t i;
        jFmt_t j;
    } instr_u;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL, ALU_LUI
    } aluOp_t;

    typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JUMP} pcSel_t;

    typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwdSel_t;

    // All zero is a bubble
    typedef struct packed {
        aluOp_t  aluOp;
        logic    useImm;
        logic    signExt;
        logic    upperImm;
        logic    link;
        logic    memRead;
        logic    memWrite;
        logic    regWrite;
        regIdx_t dest;
    } ctrl_t;

    typedef struct packed {
        logic        read;
        logic        write;
        logic [29:0] addr;     // Word address
        word_t       wdata;
    } memReq_t;

    // Operand source picked by the hazard unit
    function automatic word_t fwdMux(input fwdSel_t sel, input word_t regVal,
                                     input word_t memVal, input word_t wbVal);
        word_t val;
        case (sel)
            FWD_MEM: val = memVal;
            FWD_WB:  val = wbVal;
            default: val = regVal;
        endcase
        return val;
    endfunction

endpackage

// ==== hdl/instrDecoder.sv ====
`timescale 1ns/1ps
`include "mipsLiteDefs.svh"

module instrDecoder
    import mipsLitePkg::*;
(
    input  instr_u instr,
    input  logic   rsEqRt,     // Forwarded operands equal
    output ctrl_t  ctrl,
    output pcSel_t pcSel
);

    always_comb begin
        ctrl  = '0;            // Unknown opcodes fall through as a no-op
        pcSel = PC_SEQ;
        case (instr.i.op)
            `OP_RTYPE: begin
                ctrl.regWrite = 1'b1;
                ctrl.dest     = instr.r.rd;
                case (instr.r.funct)
                    `FN_ADDU: ctrl.aluOp = ALU_ADD;
                    `FN_SUBU: ctrl.aluOp = ALU_SUB;
                    `FN_AND:  ctrl.aluOp = ALU_AND;
                    `FN_OR:   ctrl.aluOp = ALU_OR;
                    `FN_XOR:  ctrl.aluOp = ALU_XOR;
                    `FN_SLT:  ctrl.aluOp = ALU_SLT;
                    `FN_SLL:  ctrl.aluOp = ALU_SLL;
                    default:  ctrl = '0;
                endcase
            end
            `OP_ADDIU: begin
                ctrl.aluOp    = ALU_ADD;
                ctrl.useImm   = 1'b1;
                ctrl.signExt  = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.dest     = instr.i.rt;
            end
            `OP_ORI: begin
                ctrl.aluOp    = ALU_OR;
                ctrl.useImm   = 1'b1;  // Zero extended
                ctrl.regWrite = 1'b1;
                ctrl.dest     = instr.i.rt;
            end
            `OP_LUI: begin
                ctrl.aluOp    = ALU_LUI;
                ctrl.useImm   = 1'b1;
                ctrl.upperImm = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.dest     = instr.i.rt;
            end
            `OP_LW: begin
                ctrl.aluOp    = ALU_ADD;
                ctrl.useImm   = 1'b1;
                ctrl.signExt  = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.dest     = instr.i.rt;
            end
            `OP_SW: begin
                ctrl.aluOp    = ALU_ADD;
                ctrl.useImm   = 1'b1;
                ctrl.signExt  = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            `OP_BEQ: begin
                ctrl.signExt = 1'b1;   // Branch offset is signed
                pcSel        = rsEqRt ? PC_BRANCH : PC_SEQ;
            end
            `OP_BNE: begin
                ctrl.signExt = 1'b1;
                pcSel        = rsEqRt ? PC_SEQ : PC_BRANCH;
            end
            `OP_J: pcSel = PC_JUMP;
            `OP_JAL: begin
                // Link value rides through the ALU as operand B
                ctrl.aluOp    = ALU_LUI;
                ctrl.link     = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.dest     = `LINK_REG;
                pcSel         = PC_JUMP;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

// ==== hdl/registerFile.sv ====
`timescale 1ns/1ps
`include "mipsLiteDefs.svh"

module registerFile
    import mipsLitePkg::*;
(
    input  logic    clock,
    input  logic    rst,
    input  regIdx_t readA,
    input  regIdx_t readB,
    output word_t   dataA,
    output word_t   dataB,
    input  regIdx_t writeIdx,
    input  word_t   writeData,
    input  logic    writeEn
);

    word_t regs [1 << `REG_IDX_W];
    logic  doWrite;

    assign doWrite = writeEn && (writeIdx != '0);   // r0 is never stored

    always_ff @(posedge clock) begin
        if (!rst && doWrite) regs[writeIdx] <= writeData;
    end

    // Same-cycle write shows through to decode
    function automatic word_t readPort(input regIdx_t idx);
        if (idx == '0) return '0;
        if (doWrite && idx == writeIdx) return writeData;
        return regs[idx];
    endfunction

    assign dataA = readPort(readA);
    assign dataB = readPort(readB);

endmodule

// ==== hdl/hazardUnit.sv ====
`timescale 1ns/1ps

module hazardUnit
    import mipsLitePkg::*;
(
    input  regIdx_t idRs,
    input  regIdx_t idRt,
    input  logic    idUsesRt,
    input  logic    idIsBranch,
    input  regIdx_t exRs,
    input  regIdx_t exRt,
    input  ctrl_t   exCtrl,
    input  ctrl_t   memCtrl,
    input  ctrl_t   wbCtrl,
    output fwdSel_t idFwdA,
    output fwdSel_t idFwdB,
    output fwdSel_t exFwdA,
    output fwdSel_t exFwdB,
    output logic    stall
);

    logic exHitRs;
    logic exHitRt;
    logic loadUse;
    logic branchWait;

    function automatic logic writes(input ctrl_t c, input regIdx_t src);
        return c.regWrite && (c.dest != '0) && (c.dest == src);
    endfunction

    // Memory stage is younger so it wins over writeback
    function automatic fwdSel_t pickFwd(input regIdx_t src);
        if (writes(memCtrl, src)) return FWD_MEM;
        if (writes(wbCtrl, src)) return FWD_WB;
        return FWD_REG;
    endfunction

    assign idFwdA = pickFwd(idRs);
    assign idFwdB = pickFwd(idRt);
    assign exFwdA = pickFwd(exRs);
    assign exFwdB = pickFwd(exRt);

    // Result still being computed in execute
    assign exHitRs = writes(exCtrl, idRs);
    assign exHitRt = idUsesRt && writes(exCtrl, idRt);

    assign loadUse    = exCtrl.memRead && (exHitRs || exHitRt);
    assign branchWait = idIsBranch && (exHitRs || exHitRt);   // Compare happens in decode

    assign stall = loadUse || branchWait;

endmodule

// ==== hdl/executeUnit.sv ====
`timescale 1ns/1ps

module executeUnit
    import mipsLitePkg::*;
(
    input  word_t      opA,
    input  word_t      opB,
    input  word_t      imm,        // Already extended in decode
    input  word_t      pcPlus8,
    input  logic [4:0] shamt,
    input  ctrl_t      ctrl,
    input  fwdSel_t    fwdA,
    input  fwdSel_t    fwdB,
    input  word_t      memResult,
    input  word_t      wbResult,
    output word_t      result,
    output word_t      storeData
);

    word_t valA;
    word_t valB;
    word_t aluB;

    assign valA = fwdMux(fwdA, opA, memResult, wbResult);
    assign valB = fwdMux(fwdB, opB, memResult, wbResult);

    assign storeData = valB;   // SW data is rt before the immediate mux

    // Operand B source
    always_comb begin
        if (ctrl.link) begin
            aluB = pcPlus8;
        end else if (ctrl.upperImm) begin
            aluB = {imm[15:0], 16'h0000};
        end else if (ctrl.useImm) begin
            aluB = imm;
        end else begin
            aluB = valB;
        end
    end

    always_comb begin
        case (ctrl.aluOp)
            ALU_ADD: result = valA + aluB;
            ALU_SUB: result = valA - aluB;
            ALU_AND: result = valA & aluB;
            ALU_OR:  result = valA | aluB;
            ALU_XOR: result = valA ^ aluB;
            ALU_SLT: result = ($signed(valA) < $signed(aluB)) ? word_t'(1) : '0;
            ALU_SLL: result = aluB << shamt;
            ALU_LUI: result = aluB;   // LUI and JAL pass B through
            default: result = '0;
        endcase
    end

endmodule

// ==== hdl/mipsLiteCore.sv ====
`timescale 1ns/1ps
`include "mipsLiteDefs.svh"

module mipsLiteCore
    import mipsLitePkg::*;
(
    input  logic                clock,
    input  logic                rst,
    output logic [`WORD_W-3:0]  instAddr,
    input  instr_u              instData,
    output memReq_t             dataReq,
    input  word_t               dataIn
);

    word_t   pc, pcPlus4, pcNext;
    instr_u  ifIdInstr;
    word_t   ifIdPcPlus4;
    ctrl_t   idCtrl;
    pcSel_t  idPcSel;
    word_t   rfA, rfB, idOpA, idOpB, idImm, idPcPlus8;
    word_t   branchTarget, jumpTarget;
    logic    idIsBranch, idUsesRt, stall;
    fwdSel_t idFwdA, idFwdB, exFwdA, exFwdB;
    ctrl_t   exCtrl;
    word_t   exOpA, exOpB, exImm, exPcPlus8, exResult, exStoreData;
    logic [4:0] exShamt;
    regIdx_t exRs, exRt;
    ctrl_t   memCtrl;
    word_t   memAlu, memStoreData, memResult;
    ctrl_t   wbCtrl;
    word_t   wbAlu, wbLoad, wbData;

    // Fetch
    assign pcPlus4  = pc + 32'd4;
    assign instAddr = pc[`WORD_W-1:2];

    always_comb begin
        case (idPcSel)
            PC_BRANCH: pcNext = branchTarget;
            PC_JUMP:   pcNext = jumpTarget;
            default:   pcNext = pcPlus4;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            pc        <= `RESET_PC;
            ifIdInstr <= '0;           // SLL r0 acts as a bubble
        end else if (!stall) begin
            pc        <= pcNext;
            ifIdInstr <= instData;
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) ifIdPcPlus4 <= pcPlus4;
    end

    // Decode
    assign idIsBranch = (ifIdInstr.i.op == `OP_BEQ) || (ifIdInstr.i.op == `OP_BNE);
    assign idUsesRt   = idIsBranch || (ifIdInstr.i.op == `OP_RTYPE) || (ifIdInstr.i.op == `OP_SW);

    assign idImm = idCtrl.signExt ? {{16{ifIdInstr.i.imm[15]}}, ifIdInstr.i.imm}
                                  : {16'h0000, ifIdInstr.i.imm};
    assign branchTarget = ifIdPcPlus4 + {idImm[29:0], 2'b00};
    assign jumpTarget   = {ifIdPcPlus4[31:28], ifIdInstr.j.target, 2'b00};
    assign idPcPlus8    = ifIdPcPlus4 + 32'd4;   // Return skips the delay slot

    assign idOpA = fwdMux(idFwdA, rfA, memResult, wbData);
    assign idOpB = fwdMux(idFwdB, rfB, memResult, wbData);

    instrDecoder instrDecoder_inst (
        .instr  (ifIdInstr),
        .rsEqRt (idOpA == idOpB),
        .ctrl   (idCtrl),
        .pcSel  (idPcSel)
    );

    registerFile registerFile_inst (
        .clock     (clock),
        .rst       (rst),
        .readA     (ifIdInstr.r.rs),
        .readB     (ifIdInstr.r.rt),
        .dataA     (rfA),
        .dataB     (rfB),
        .writeIdx  (wbCtrl.dest),
        .writeData (wbData),
        .writeEn   (wbCtrl.regWrite)
    );

    hazardUnit hazardUnit_inst (
        .idRs       (ifIdInstr.r.rs),
        .idRt       (ifIdInstr.r.rt),
        .idUsesRt   (idUsesRt),
        .idIsBranch (idIsBranch),
        .exRs       (exRs),
        .exRt       (exRt),
        .exCtrl     (exCtrl),
        .memCtrl    (memCtrl),
        .wbCtrl     (wbCtrl),
        .idFwdA     (idFwdA),
        .idFwdB     (idFwdB),
        .exFwdA     (exFwdA),
        .exFwdB     (exFwdB),
        .stall      (stall)
    );

    // Decode to execute, bubble on stall
    always_ff @(posedge clock) begin
        if (rst || stall) exCtrl <= '0;
        else exCtrl <= idCtrl;
    end

    always_ff @(posedge clock) begin
        exOpA     <= idOpA;
        exOpB     <= idOpB;
        exImm     <= idImm;
        exPcPlus8 <= idPcPlus8;
        exShamt   <= ifIdInstr.r.shamt;
        exRs      <= ifIdInstr.r.rs;
        exRt      <= ifIdInstr.r.rt;
    end

    executeUnit executeUnit_inst (
        .opA       (exOpA),
        .opB       (exOpB),
        .imm       (exImm),
        .pcPlus8   (exPcPlus8),
        .shamt     (exShamt),
        .ctrl      (exCtrl),
        .fwdA      (exFwdA),
        .fwdB      (exFwdB),
        .memResult (memResult),
        .wbResult  (wbData),
        .result    (exResult),
        .storeData (exStoreData)
    );

    // Execute to memory
    always_ff @(posedge clock) begin
        if (rst) memCtrl <= '0;
        else memCtrl <= exCtrl;
    end

    always_ff @(posedge clock) begin
        memAlu       <= exResult;
        memStoreData <= exStoreData;
    end

    assign dataReq.read  = memCtrl.memRead;
    assign dataReq.write = memCtrl.memWrite;
    assign dataReq.addr  = memAlu[`WORD_W-1:2];
    assign dataReq.wdata = memStoreData;

    assign memResult = memCtrl.memRead ? dataIn : memAlu;   // Load data returns this cycle

    // Memory to writeback
    always_ff @(posedge clock) begin
        if (rst) wbCtrl <= '0;
        else wbCtrl <= memCtrl;
    end

    always_ff @(posedge clock) begin
        wbAlu  <= memAlu;
        wbLoad <= dataIn;
    end

    assign wbData = wbCtrl.memRead ? wbLoad : wbAlu;

endmodule

// ==== dv/mipsLiteRef.svh ====
`ifndef MIPS_LITE_REF_SVH
`define MIPS_LITE_REF_SVH

// Instruction encoders
function automatic word_t encR(input logic [5:0] fn, input regIdx_t rs, input regIdx_t rt,
                               input regIdx_t rd, input logic [4:0] sh);
    return {`OP_RTYPE, rs, rt, rd, sh, fn};
endfunction

function automatic word_t encI(input logic [5:0] op, input regIdx_t rs, input regIdx_t rt,
                               input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic word_t encJ(input logic [5:0] op, input logic [25:0] target);
    return {op, target};
endfunction

function void emit(input word_t w);
    imem[progLen] = w;
    progLen++;
endfunction

function void clearProgram();
    for (int i = 0; i < 256; i++) imem[i] = '0;   // Zero word is SLL r0, a no-op
    progLen = 0;
endfunction

// Preload value, mixes every address bit
function automatic word_t memFill(input int idx);
    return (idx * 32'h9E37_79B1) ^ 32'h5A5A_0000;
endfunction

// ISA-level model with one delay slot, collects the stores in order
function void runReference();
    word_t regs [32];
    word_t pc, npc, nxt, w, a, b, res, simm, ea;
    logic [15:0] imm;
    regIdx_t dst;
    logic done;
    for (int i = 0; i < 32; i++) regs[i] = '0;
    for (int i = 0; i < 256; i++) refMem[i] = memFill(i);
    expAddr.delete();
    expData.delete();
    pc   = `RESET_PC;
    npc  = pc + 4;
    done = 1'b0;
    for (int steps = 0; steps < 4000 && !done; steps++) begin
        w    = imem[pc[9:2]];
        imm  = w[15:0];
        simm = {{16{imm[15]}}, imm};
        a    = regs[w[25:21]];
        b    = regs[w[20:16]];
        ea   = a + simm;
        nxt  = npc + 4;
        dst  = '0;
        res  = '0;
        case (w[31:26])
            `OP_RTYPE: begin
                dst = w[15:11];
                case (w[5:0])
                    `FN_ADDU: res = a + b;
                    `FN_SUBU: res = a - b;
                    `FN_AND:  res = a & b;
                    `FN_OR:   res = a | b;
                    `FN_XOR:  res = a ^ b;
                    `FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    `FN_SLL:  res = b << w[10:6];
                    default:  dst = '0;
                endcase
            end
            `OP_ADDIU: begin dst = w[20:16]; res = a + simm; end
            `OP_ORI:   begin dst = w[20:16]; res = a | {16'h0000, imm}; end
            `OP_LUI:   begin dst = w[20:16]; res = {imm, 16'h0000}; end
            `OP_LW:    begin dst = w[20:16]; res = refMem[ea[9:2]]; end
            `OP_SW: begin
                refMem[ea[9:2]] = b;
                expAddr.push_back(ea[31:2]);
                expData.push_back(b);
                done = (ea[31:2] == markWord);
            end
            `OP_BEQ: if (a == b) nxt = npc + (simm << 2);
            `OP_BNE: if (a != b) nxt = npc + (simm << 2);
            `OP_J:   nxt = {npc[31:28], w[25:0], 2'b00};
            `OP_JAL: begin dst = `LINK_REG; res = pc + 8; nxt = {npc[31:28], w[25:0], 2'b00}; end
            default: dst = '0;
        endcase
        if (dst != '0) regs[dst] = res;
        pc  = npc;
        npc = nxt;
    end
endfunction

`endif

// ==== dv/mipsLiteTb.sv ====
`timescale 1ns/1ps
`include "mipsLiteDefs.svh"

module mipsLiteTb
    import mipsLitePkg::*;
();

    localparam logic [29:0] markWord = 30'd255;
    localparam logic [15:0] markOff  = 16'h03FC;   // Byte offset of the end marker

    logic        clock, rst, loadMem, running, markerSeen, testActive;
    logic [29:0] instAddr;
    instr_u      instData;
    memReq_t     dataReq;
    word_t       dataIn;
    word_t       imem [256];
    word_t       dmem [256];
    word_t       refMem [256];
    logic [29:0] expAddr [$];
    word_t       expData [$];
    int          progLen, storeIdx, errors, checks, testsRun;
    time         deadline;
    string       curName;

    `include "mipsLiteRef.svh"

    mipsLiteCore mipsLiteCore_inst (
        .clock    (clock),
        .rst      (rst),
        .instAddr (instAddr),
        .instData (instData),
        .dataReq  (dataReq),
        .dataIn   (dataIn)
    );

    assign instData = imem[instAddr[7:0]];
    assign dataIn   = dmem[dataReq.addr[7:0]];   // Same-cycle read

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) begin
        if (loadMem) begin
            for (int i = 0; i < 256; i++) dmem[i] <= memFill(i);
        end else if (dataReq.write) begin
            dmem[dataReq.addr[7:0]] <= dataReq.wdata;
        end
    end

    task automatic checkReset(input memReq_t got);
        checks++;
        if (got.read || got.write) begin
            errors++;
            $display("Error at %0t: read %0b write %0b while the pipeline is empty",
                     $time, got.read, got.write);
        end
    endtask

    task automatic checkFetch(input logic [29:0] got, input logic [29:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: fetch address %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic checkStore(input memReq_t got);
        checks++;
        if (storeIdx >= expData.size()) begin
            errors++;
            $display("Error at %0t: extra store of %h to word %0d", $time, got.wdata, got.addr);
        end else if (got.addr !== expAddr[storeIdx] || got.wdata !== expData[storeIdx]) begin
            errors++;
            $display("Error at %0t: store %0d wrote %h to word %0d, expected %h to word %0d",
                     $time, storeIdx, got.wdata, got.addr, expData[storeIdx], expAddr[storeIdx]);
        end
        storeIdx++;
    endtask

    // Request is stable at the falling edge
    always @(negedge clock) begin
        if (running && dataReq.write) begin
            checkStore(dataReq);
            if (dataReq.addr == markWord) markerSeen = 1'b1;
        end
    end

    initial begin
        @(posedge clock);
        while (!testActive || $time <= deadline) @(posedge clock);
        $display("Timeout: %s never reached its end marker store", curName);
        $display("test failed");
        $finish;
    end

    task automatic runTest(input string name);
        int errBefore;
        errBefore = errors;
        curName   = name;
        runReference();
        @(negedge clock);
        rst        = 1'b1;
        loadMem    = 1'b1;
        running    = 1'b0;
        markerSeen = 1'b0;
        storeIdx   = 0;
        repeat (16) begin
            @(negedge clock);
            checkReset(dataReq);
        end
        rst        = 1'b0;
        loadMem    = 1'b0;
        running    = 1'b1;
        deadline   = $time + (progLen * 20 + 100) * 100;
        testActive = 1'b1;
        checkFetch(instAddr, 30'(`RESET_PC >> 2));
        repeat (3) begin   // Bubbles still ahead of the first instruction
            checkReset(dataReq);
            @(negedge clock);
        end
        while (!markerSeen) @(negedge clock);
        running    = 1'b0;
        testActive = 1'b0;
        checks++;
        if (storeIdx != expData.size()) begin
            errors++;
            $display("Error at %0t: %0d stores seen, expected %0d", $time, storeIdx, expData.size());
        end
        testsRun++;
        $display("%-12s %0d stores, %0d errors", name, storeIdx, errors - errBefore);
    endtask

    task automatic buildAlu();
        clearProgram();
        emit(encI(`OP_ADDIU, 0, 1, 16'd5));
        emit(encI(`OP_ADDIU, 1, 2, 16'd7));      // From memory stage
        emit(encR(`FN_ADDU, 1, 2, 3, 0));        // Both stages at once
        emit(encR(`FN_SUBU, 3, 1, 4, 0));
        emit(encR(`FN_SLL, 0, 4, 5, 5'd3));
        emit(encR(`FN_XOR, 5, 3, 6, 0));
        emit(encR(`FN_SLT, 4, 6, 7, 0));
        emit(encI(`OP_LUI, 0, 8, 16'h1234));
        emit(encI(`OP_ORI, 8, 8, 16'h5678));
        emit(encR(`FN_AND, 8, 6, 9, 0));
        emit(encR(`FN_OR, 9, 2, 10, 0));
        emit(encI(`OP_SW, 0, 3, 16'd0));
        emit(encI(`OP_SW, 0, 10, 16'd4));
        emit(encI(`OP_SW, 0, 7, 16'd8));
        emit(encI(`OP_SW, 0, 8, 16'd12));
        emit(encI(`OP_SW, 0, 5, markOff));
    endtask

    task automatic buildLoad();
        clearProgram();
        emit(encI(`OP_LW, 0, 1, 16'd16));
        emit(encR(`FN_ADDU, 1, 1, 2, 0));        // Load-use stall
        emit(encI(`OP_SW, 0, 2, 16'd20));
        emit(encI(`OP_LW, 0, 3, 16'd24));
        emit(encI(`OP_ADDIU, 3, 4, 16'd1));
        emit(encI(`OP_LW, 0, 5, 16'd28));
        emit(encI(`OP_SW, 0, 5, 16'd32));        // Store data straight from a load
        emit(encI(`OP_LW, 0, 6, 16'd28));        // Same word as r5
        emit(encI(`OP_BEQ, 6, 5, 16'd2));        // Branch on loaded value
        emit(encI(`OP_ADDIU, 4, 4, 16'd2));
        emit(encI(`OP_ADDIU, 4, 4, 16'd100));    // Skipped
        emit(encI(`OP_SW, 0, 4, markOff));
    endtask

    task automatic buildBranch();
        clearProgram();
        emit(encI(`OP_ADDIU, 0, 1, 16'd3));
        emit(encI(`OP_ADDIU, 0, 2, 16'd3));
        emit(encI(`OP_BEQ, 1, 2, 16'd2));        // Taken to 5
        emit(encI(`OP_ADDIU, 0, 3, 16'd11));
        emit(encI(`OP_ADDIU, 0, 3, 16'd99));
        emit(encI(`OP_SW, 0, 3, 16'd40));
        emit(encI(`OP_BNE, 1, 2, 16'd2));        // Not taken
        emit(encI(`OP_ADDIU, 0, 4, 16'd22));
        emit(encI(`OP_SW, 0, 4, 16'd44));
        emit(encI(`OP_BNE, 1, 0, 16'd2));        // Taken to 12
        emit(encI(`OP_ADDIU, 0, 5, 16'd33));
        emit(encI(`OP_ADDIU, 0, 5, 16'd77));
        emit(encI(`OP_BEQ, 1, 0, 16'd2));        // Not taken
        emit(encI(`OP_ADDIU, 0, 6, 16'd44));
        emit(encJ(`OP_J, 26'd17));
        emit(encI(`OP_ADDIU, 0, 7, 16'd55));
        emit(encI(`OP_ADDIU, 0, 7, 16'd66));
        emit(encJ(`OP_JAL, 26'd20));
        emit(encI(`OP_SW, 0, 7, 16'd48));        // Delay slot of JAL
        emit(encI(`OP_ADDIU, 0, 5, 16'd88));
        emit(encI(`OP_SW, 0, 31, 16'd52));
        emit(encI(`OP_SW, 0, 5, 16'd56));
        emit(encI(`OP_SW, 0, 6, markOff));
    endtask

    task automatic buildRandom();
        logic [5:0] fns [7] = '{`FN_ADDU, `FN_SUBU, `FN_AND, `FN_OR, `FN_XOR, `FN_SLT, `FN_SLL};
        int kind;
        regIdx_t rs, rt, rd;
        clearProgram();
        for (int r = 1; r < 8; r++) emit(encI(`OP_ADDIU, 0, regIdx_t'(r), 16'($urandom)));
        repeat (150) begin
            kind = $urandom % 12;
            rs   = regIdx_t'(1 + $urandom % 7);
            rt   = regIdx_t'(1 + $urandom % 7);
            rd   = regIdx_t'(1 + $urandom % 7);
            case (kind)
                7:  emit(encI(`OP_ADDIU, rs, rt, 16'($urandom)));
                8:  emit(encI(`OP_ORI, rs, rt, 16'($urandom)));
                9:  emit(encI(`OP_LUI, 0, rt, 16'($urandom)));
                10: emit(encI(`OP_LW, 0, rt, 16'(($urandom % 254) * 4)));
                11: emit(encI(`OP_SW, 0, rt, 16'(($urandom % 254) * 4)));
                default: emit(encR(fns[kind], rs, rt, rd, 5'($urandom)));
            endcase
        end
        emit(encI(`OP_SW, 0, 1, markOff));
    endtask

    initial begin
        rst        = 1'b1;
        loadMem    = 1'b0;
        running    = 1'b0;
        markerSeen = 1'b0;
        testActive = 1'b0;
        errors     = 0;
        checks     = 0;
        testsRun   = 0;
        void'($urandom(72543));
        buildAlu();
        runTest("aluChain");
        buildLoad();
        runTest("loadUse");
        buildBranch();
        runTest("branches");
        buildRandom();
        runTest("random");
        $display("tests %0d, checks %0d, errors %0d", testsRun, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== mipsLite.f ====
+incdir+hdl
+incdir+dv
hdl/mipsLitePkg.sv
hdl/instrDecoder.sv
hdl/registerFile.sv
hdl/hazardUnit.sv
hdl/executeUnit.sv
hdl/mipsLiteCore.sv
dv/mipsLiteTb.sv

// ==== runSim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module mipsLiteTb -f mipsLite.f -o simMipsLite
./obj_dir/simMipsLite > sim.log 2>&1
cat sim.log

if grep -q "test failed" sim.log; then
    exit 1
fi
exit 0
